//--- logic/deskew_config.svh
`ifndef DESKEW_CONFIG_SVH
`define DESKEW_CONFIG_SVH

// Number of physical lanes in the receive bundle
`define DESKEW_N_LANES 4

// Data bits carried per lane on each valid beat
`define DESKEW_LANE_W 8

// Largest correctable skew between lanes, in valid beats
`define DESKEW_MAX_SKEW 14

// Counter and delay width
// Must hold MAX_SKEW+1 so overflow is seen before saturation
`define DESKEW_NB_COUNT 4

`endif

//--- logic/deskew_pkg.sv
`default_nettype none
`include "deskew_config.svh"

package deskew_pkg;

  // Deskew controller states
  typedef enum logic [2:0]
  {
    ST_IDLE        = 3'd0,
    ST_WAIT_MARKER = 3'd1,
    ST_MEASURE     = 3'd2,
    ST_SET_DELAY   = 3'd3,
    ST_ALIGNED     = 3'd4
  } deskew_state_e;

  // Skew count or programmed lane delay, in valid beats
  typedef logic [`DESKEW_NB_COUNT-1:0] lane_delay_t;

endpackage

`default_nettype wire

//--- logic/deskew_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "deskew_config.svh"

interface deskew_ctrl_if
(
  input wire i_clock
);

  // Counter sequencing from the FSM
  logic                        count_clear;
  logic                        count_enable;
  logic [`DESKEW_N_LANES-1:0]  lane_stop;
  logic                        all_stop;

  // Common skew count, largest lane offset once all lanes are seen
  logic [`DESKEW_NB_COUNT-1:0] common_count;

  // Delay line load strobe and marker feedback
  logic                        delay_load;

  // One bit per lane, each driven by its own delay line
  wire  [`DESKEW_N_LANES-1:0]  delayed_marker;

  modport fsm
  (
    input  i_clock,
    output count_clear,
    output count_enable,
    output lane_stop,
    output all_stop,
    output delay_load,
    input  common_count,
    input  delayed_marker
  );

  modport counter
  (
    input  i_clock,
    input  count_clear,
    input  count_enable,
    input  lane_stop,
    input  all_stop,
    output common_count
  );

  // Delay lines need the common count to form their delay at load time
  modport delay
  (
    input  i_clock,
    input  delay_load,
    input  common_count,
    output delayed_marker
  );

endinterface

`default_nettype wire

//--- logic/deskew_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "deskew_config.svh"

module deskew_fsm
(
  input  wire                       i_clock,
  input  wire                       i_rst_n,
  input  wire                       i_enable,
  input  wire                       i_valid,
  input  wire [`DESKEW_N_LANES-1:0] i_resync,
  input  wire [`DESKEW_N_LANES-1:0] i_start_of_lane,
  deskew_ctrl_if.fsm                ctrl,
  output wire                       o_set_fifo_delay,
  output wire                       o_align_status,
  output wire                       o_skew_error
);

  localparam int N_LANES = `DESKEW_N_LANES;

  localparam deskew_pkg::lane_delay_t MAX_SKEW_C =
    deskew_pkg::lane_delay_t'(`DESKEW_MAX_SKEW);

  deskew_pkg::deskew_state_e state_q;
  deskew_pkg::deskew_state_e state_d;

  // Per-lane marker seen flags, these stop the lane counters
  logic [N_LANES-1:0] seen_q;
  logic [N_LANES-1:0] seen_d;

  // Qualifies the registered outputs of the delay lines
  logic               out_valid_q;

  logic               resync;
  logic               first_marker;
  logic               overflow;
  logic               split_marker;
  logic               load_delay;

  assign resync       = |i_resync;
  assign first_marker = i_valid && (|i_start_of_lane);
  assign overflow     = ctrl.common_count > MAX_SKEW_C;

  // Some but not all delayed markers on a fresh output beat
  assign split_marker = out_valid_q && (|ctrl.delayed_marker) && !(&ctrl.delayed_marker);

  always_comb
  begin
    state_d = state_q;
    seen_d  = seen_q;
    case (state_q)
      deskew_pkg::ST_IDLE:
      begin
        seen_d  = '0;
        state_d = deskew_pkg::ST_WAIT_MARKER;
      end
      deskew_pkg::ST_WAIT_MARKER:
      begin
        // Lanes marked on the first beat get offset 0
        seen_d = first_marker ? i_start_of_lane : '0;
        if (first_marker)
        begin
          state_d = deskew_pkg::ST_MEASURE;
        end
      end
      deskew_pkg::ST_MEASURE:
      begin
        if (i_valid)
        begin
          seen_d = seen_q | i_start_of_lane;
        end
        if (overflow)
        begin
          state_d = deskew_pkg::ST_WAIT_MARKER;
        end
        else if (ctrl.all_stop)
        begin
          state_d = deskew_pkg::ST_SET_DELAY;
        end
      end
      deskew_pkg::ST_SET_DELAY:
      begin
        state_d = deskew_pkg::ST_ALIGNED;
      end
      deskew_pkg::ST_ALIGNED:
      begin
        if (split_marker)
        begin
          state_d = deskew_pkg::ST_WAIT_MARKER;
        end
      end
      default:
      begin
        state_d = deskew_pkg::ST_IDLE;
      end
    endcase

    // Resync restarts measurement, delays already loaded stay put
    if (resync)
    begin
      state_d = deskew_pkg::ST_WAIT_MARKER;
    end
    if (!i_enable)
    begin
      state_d = deskew_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (!i_rst_n)
    begin
      state_q     <= deskew_pkg::ST_IDLE;
      seen_q      <= '0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      seen_q      <= seen_d;
      out_valid_q <= i_valid;
    end
  end

  // Counters held clear until the first marker
  assign ctrl.count_clear  = (state_q == deskew_pkg::ST_IDLE) ||
                             (state_q == deskew_pkg::ST_WAIT_MARKER);
  assign ctrl.count_enable = state_q == deskew_pkg::ST_MEASURE;
  assign ctrl.lane_stop    = seen_q;
  assign ctrl.all_stop     = &seen_q;

  assign load_delay        = state_q == deskew_pkg::ST_SET_DELAY;
  assign ctrl.delay_load   = load_delay;
  assign o_set_fifo_delay  = load_delay;

  assign o_align_status    = state_q == deskew_pkg::ST_ALIGNED;

  // High for the single cycle before the return to marker search
  assign o_skew_error      = (state_q == deskew_pkg::ST_MEASURE) && overflow;

endmodule

`default_nettype wire

//--- logic/skew_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "deskew_config.svh"

module skew_counter
#(
  // Set on the instance that sources the common count
  parameter bit DRIVE_COMMON = 1'b0
)
(
  input  wire                     i_clock,
  input  wire                     i_rst_n,
  input  wire                     i_valid,
  input  wire                     i_stop,
  deskew_ctrl_if.counter          ctrl,
  output deskew_pkg::lane_delay_t o_count
);

  deskew_pkg::lane_delay_t count_q;
  logic                    advance;

  // Count only real beats, hold at all ones
  assign advance = i_valid && ctrl.count_enable && !i_stop && (count_q != '1);

  always_ff @(posedge i_clock)
  begin
    if (!i_rst_n)
    begin
      count_q <= '0;
    end
    else if (ctrl.count_clear)
    begin
      count_q <= '0;
    end
    else if (advance)
    begin
      count_q <= count_q + 1'b1;
    end
  end

  assign o_count = count_q;

  generate
    if (DRIVE_COMMON)
    begin : g_common
      assign ctrl.common_count = count_q;
    end
  endgenerate

endmodule

`default_nettype wire

//--- logic/lane_delay_line.sv
`timescale 1ns/1ps
`default_nettype none
`include "deskew_config.svh"

module lane_delay_line
#(
  // Bit of delayed_marker owned by this lane
  parameter int LANE_IDX = 0
)
(
  input  wire                       i_clock,
  input  wire                       i_rst_n,
  input  wire                       i_valid,
  input  wire [`DESKEW_LANE_W-1:0]  i_data,
  input  wire                       i_marker,
  input  deskew_pkg::lane_delay_t   i_lane_count,
  deskew_ctrl_if.delay              ctrl,
  output logic [`DESKEW_LANE_W-1:0] o_data,
  output logic                      o_marker,
  output deskew_pkg::lane_delay_t   o_delay
);

  localparam int LANE_W = `DESKEW_LANE_W;

  // Tap 0 is the current beat, taps 1..MAX_SKEW are history
  localparam int DEPTH  = `DESKEW_MAX_SKEW + 1;

  logic [LANE_W-1:0]       data_sr [DEPTH-1];
  logic [DEPTH-2:0]        marker_sr;
  deskew_pkg::lane_delay_t delay_q;
  logic [LANE_W-1:0]       tap_data;
  logic                    tap_marker;

  // History advances on valid beats only
  always_ff @(posedge i_clock)
  begin
    if (i_valid)
    begin
      data_sr[0] <= i_data;
      for (int k = 1; k < DEPTH - 1; k++)
      begin
        data_sr[k] <= data_sr[k-1];
      end
      o_data <= tap_data;
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (!i_rst_n)
    begin
      marker_sr <= '0;
    end
    else if (i_valid)
    begin
      marker_sr <= {marker_sr[DEPTH-3:0], i_marker};
    end
  end

  // Tap select, delays past the deepest tap use the oldest entry
  always_comb
  begin
    tap_data   = i_data;
    tap_marker = i_marker;
    for (int k = 1; k < DEPTH; k++)
    begin
      if (delay_q >= k)
      begin
        tap_data   = data_sr[k-1];
        tap_marker = marker_sr[k-1];
      end
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (!i_rst_n)
    begin
      delay_q  <= '0;
      o_marker <= 1'b0;
    end
    else
    begin
      // Early lanes wait out the gap to the latest lane
      if (ctrl.delay_load)
      begin
        delay_q <= ctrl.common_count - i_lane_count;
      end
      if (i_valid)
      begin
        o_marker <= tap_marker;
      end
    end
  end

  assign o_delay                       = delay_q;
  assign ctrl.delayed_marker[LANE_IDX] = o_marker;

endmodule

`default_nettype wire

//--- logic/deskew_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "deskew_config.svh"

module deskew_top
(
  input  wire                                         i_clock,
  input  wire                                         i_rst_n,
  input  wire                                         i_enable,
  input  wire                                         i_valid,
  input  wire [`DESKEW_N_LANES-1:0]                   i_resync,
  input  wire [`DESKEW_N_LANES-1:0]                   i_start_of_lane,
  input  wire [`DESKEW_N_LANES*`DESKEW_LANE_W-1:0]    i_lane_data,
  output wire [`DESKEW_N_LANES*`DESKEW_LANE_W-1:0]    o_lane_data,
  output wire [`DESKEW_N_LANES-1:0]                   o_lane_marker,
  output wire                                         o_out_valid,
  output wire                                         o_set_fifo_delay,
  output wire [`DESKEW_N_LANES*`DESKEW_NB_COUNT-1:0]  o_lane_delay,
  output wire                                         o_align_status,
  output wire                                         o_skew_error
);

  localparam int N_LANES  = `DESKEW_N_LANES;
  localparam int LANE_W   = `DESKEW_LANE_W;
  localparam int NB_COUNT = $bits(deskew_pkg::lane_delay_t);

  // Frozen per-lane arrival offsets
  wire [N_LANES*NB_COUNT-1:0] lane_count;

  logic                       out_valid_q;

  deskew_ctrl_if u_ctrl_if
  (
    .i_clock (i_clock)
  );

  deskew_fsm u_deskew_fsm
  (
    .i_clock          (i_clock),
    .i_rst_n          (i_rst_n),
    .i_enable         (i_enable),
    .i_valid          (i_valid),
    .i_resync         (i_resync),
    .i_start_of_lane  (i_start_of_lane),
    .ctrl             (u_ctrl_if),
    .o_set_fifo_delay (o_set_fifo_delay),
    .o_align_status   (o_align_status),
    .o_skew_error     (o_skew_error)
  );

  // Runs from the first marker until every lane has been seen
  skew_counter
  #(
    .DRIVE_COMMON (1'b1)
  )
  u_common_counter
  (
    .i_clock (i_clock),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_stop  (u_ctrl_if.all_stop),
    .ctrl    (u_ctrl_if),
    .o_count ()
  );

  for (genvar i = 0; i < N_LANES; i++)
  begin : g_lane
    skew_counter u_lane_counter
    (
      .i_clock (i_clock),
      .i_rst_n (i_rst_n),
      .i_valid (i_valid),
      .i_stop  (u_ctrl_if.lane_stop[i]),
      .ctrl    (u_ctrl_if),
      .o_count (lane_count[i*NB_COUNT +: NB_COUNT])
    );

    lane_delay_line
    #(
      .LANE_IDX (i)
    )
    u_lane_delay
    (
      .i_clock      (i_clock),
      .i_rst_n      (i_rst_n),
      .i_valid      (i_valid),
      .i_data       (i_lane_data[i*LANE_W +: LANE_W]),
      .i_marker     (i_start_of_lane[i]),
      .i_lane_count (lane_count[i*NB_COUNT +: NB_COUNT]),
      .ctrl         (u_ctrl_if),
      .o_data       (o_lane_data[i*LANE_W +: LANE_W]),
      .o_marker     (o_lane_marker[i]),
      .o_delay      (o_lane_delay[i*NB_COUNT +: NB_COUNT])
    );
  end

  // Matches the output register stage of the delay lines
  always_ff @(posedge i_clock)
  begin
    if (!i_rst_n)
    begin
      out_valid_q <= 1'b0;
    end
    else
    begin
      out_valid_q <= i_valid;
    end
  end

  assign o_out_valid = out_valid_q;

endmodule

`default_nettype wire

//--- verification/deskew_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "deskew_config.svh"

module deskew_tb;

  localparam int N_LANES       = `DESKEW_N_LANES;
  localparam int LANE_W        = `DESKEW_LANE_W;
  localparam int NB_COUNT      = `DESKEW_NB_COUNT;
  localparam int CLK_PERIOD    = 4;
  localparam int MARKER_PERIOD = 32;
  localparam int N_TESTS       = 6;
  localparam int WATCHDOG_NS   = 8 * MARKER_PERIOD * N_TESTS * CLK_PERIOD;
  // Room for one failed measurement plus a clean one
  localparam int WAIT_LIMIT    = 8 * MARKER_PERIOD;

  logic                        i_clock;
  logic                        i_rst_n;
  logic                        i_enable;
  logic                        i_valid;
  logic [N_LANES-1:0]          i_resync;
  logic [N_LANES-1:0]          i_start_of_lane;
  logic [N_LANES*LANE_W-1:0]   i_lane_data;
  wire  [N_LANES*LANE_W-1:0]   o_lane_data;
  wire  [N_LANES-1:0]          o_lane_marker;
  wire                         o_out_valid;
  wire                         o_set_fifo_delay;
  wire  [N_LANES*NB_COUNT-1:0] o_lane_delay;
  wire                         o_align_status;
  wire                         o_skew_error;

  integer                      seed;
  int                          errors = 0;
  string                       test_name = "none";

  // Lane i carries byte beat - skew[i] with a marker every 32 bytes
  int                          skew [N_LANES];
  int                          skew_max;
  int                          beat;
  logic [LANE_W-1:0]           ref_byte;
  logic [LANE_W-1:0]           exp_byte_q;
  logic [N_LANES-1:0]          exp_marker_q;
  logic [N_LANES*NB_COUNT-1:0] exp_delay;

  logic                        aligned_q;
  logic                        valid_q;
  bit                          check_stream = 1'b0;
  bit                          in_skew_test = 1'b0;
  int                          set_pulses = 0;
  int                          skew_errors = 0;

  deskew_top i_dut
  (
    .i_clock          (i_clock),
    .i_rst_n          (i_rst_n),
    .i_enable         (i_enable),
    .i_valid          (i_valid),
    .i_resync         (i_resync),
    .i_start_of_lane  (i_start_of_lane),
    .i_lane_data      (i_lane_data),
    .o_lane_data      (o_lane_data),
    .o_lane_marker    (o_lane_marker),
    .o_out_valid      (o_out_valid),
    .o_set_fifo_delay (o_set_fifo_delay),
    .o_lane_delay     (o_lane_delay),
    .o_align_status   (o_align_status),
    .o_skew_error     (o_skew_error)
  );

  initial
  begin
    i_clock = 1'b0;
    forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
  end

  // Output beat reference registered like the delay line outputs
  always @(posedge i_clock)
  begin
    aligned_q <= o_align_status;
    valid_q   <= i_valid;
    if (i_valid)
    begin
      exp_byte_q   <= ref_byte;
      exp_marker_q <= {N_LANES{(ref_byte % MARKER_PERIOD) == 0}};
    end
    if (o_set_fifo_delay)
    begin
      set_pulses <= set_pulses + 1;
    end
    if (o_skew_error)
    begin
      skew_errors <= skew_errors + 1;
    end
  end

  task automatic value_failure(input string what, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    errors++;
    $display("Fail %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
  endtask

  task automatic event_failure(input string what);
    errors++;
    $display("Error in %s: %s", test_name, what);
  endtask

  task automatic expect_value(input string what, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
    assert (exp_val === act_val)
    else value_failure(what, exp_val, act_val);
  endtask

  a_out_valid: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    o_out_valid == valid_q)
  else value_failure("o_out_valid", valid_q, o_out_valid);

  // First ALIGNED cycle still shows a beat taken with the old delays
  // All lanes mark the start of each 32 byte period together
  a_marker_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (check_stream && o_align_status && aligned_q && o_out_valid) |->
      (o_lane_marker == exp_marker_q))
  else value_failure("lane markers", exp_marker_q, o_lane_marker);

  a_data_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (check_stream && o_align_status && aligned_q && o_out_valid) |->
      (o_lane_data == {N_LANES{exp_byte_q}}))
  else value_failure("lane data", {N_LANES{exp_byte_q}}, o_lane_data);

  a_delay_load: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    o_set_fifo_delay |=> (o_lane_delay == exp_delay))
  else value_failure("lane delay", exp_delay, o_lane_delay);

  a_align_after_load: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    o_set_fifo_delay |=> (o_align_status && !o_set_fifo_delay))
  else event_failure("align status did not follow a single delay load pulse");

  a_split_drop: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (o_align_status && o_out_valid && o_lane_marker != '0 && o_lane_marker != '1)
      |=> !o_align_status)
  else event_failure("align status stayed high after split markers");

  a_resync_drop: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    (|i_resync) |=> !o_align_status)
  else event_failure("align status stayed high after resync");

  a_no_align_on_overflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    in_skew_test |-> !o_align_status)
  else event_failure("align status went high with an uncorrectable skew");

  function automatic deskew_pkg::lane_delay_t expected_delay(input int lane);
    expected_delay = deskew_pkg::lane_delay_t'(skew_max - skew[lane]);
  endfunction

  // Reference delays follow the largest skew
  task automatic update_reference();
    skew_max = 0;
    for (int i = 0; i < N_LANES; i++)
    begin
      if (skew[i] > skew_max)
      begin
        skew_max = skew[i];
      end
    end
    for (int i = 0; i < N_LANES; i++)
    begin
      exp_delay[i*NB_COUNT +: NB_COUNT] = expected_delay(i);
    end
  endtask

  task automatic random_skews(input int limit);
    for (int i = 0; i < N_LANES; i++)
    begin
      skew[i] = {$random(seed)} % (limit + 1);
    end
    beat = 0;
    update_reference();
  endtask

  task automatic drive_beat();
    int lane_byte;
    @(posedge i_clock);
    #1;
    i_resync        = '0;
    i_valid         = (($random(seed) & 7) != 0);
    i_start_of_lane = '0;
    if (i_valid)
    begin
      for (int i = 0; i < N_LANES; i++)
      begin
        lane_byte = beat - skew[i];
        i_lane_data[i*LANE_W +: LANE_W] = LANE_W'(lane_byte);
        i_start_of_lane[i] = (lane_byte >= 0) && (lane_byte % MARKER_PERIOD == 0);
      end
      ref_byte = LANE_W'(beat - skew_max);
      beat++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge i_clock);
      #1;
      i_valid         = 1'b0;
      i_start_of_lane = '0;
      i_resync        = '0;
    end
  endtask

  // Streams beats until a new delay load, or until align status is high
  task automatic run_until(input bit want_align);
    int start;
    int cycles;
    start  = set_pulses;
    cycles = 0;
    while (!(want_align ? o_align_status : (set_pulses != start)) && cycles < WAIT_LIMIT)
    begin
      drive_beat();
      cycles++;
    end
    if (cycles >= WAIT_LIMIT)
    begin
      event_failure(want_align ? "align status never rose" : "no delay load pulse arrived");
    end
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    int pulses_before;
    int errors_before;
    seed            = 53;
    i_rst_n         = 1'b0;
    i_enable        = 1'b0;
    i_valid         = 1'b0;
    i_resync        = '0;
    i_start_of_lane = '0;
    i_lane_data     = '0;
    ref_byte        = '0;
    repeat (5) @(posedge i_clock);
    #1;
    i_rst_n = 1'b1;

    test_name = "reset_values";
    expect_value("o_set_fifo_delay", 0, o_set_fifo_delay);
    expect_value("o_align_status", 0, o_align_status);
    expect_value("o_skew_error", 0, o_skew_error);
    expect_value("o_out_valid", 0, o_out_valid);
    expect_value("o_lane_delay", 0, o_lane_delay);
    i_enable = 1'b1;
    idle_cycles(2);

    test_name = "random_skew";
    random_skews(10);
    check_stream  = 1'b1;
    pulses_before = set_pulses;
    run_until(1'b0);
    run_beats_loop: repeat (4 * MARKER_PERIOD) drive_beat();
    expect_value("delay load pulses", 1, set_pulses - pulses_before);

    test_name = "resync";
    expect_value("o_align_status before resync", 1, o_align_status);
    @(posedge i_clock);
    #1;
    i_valid         = 1'b0;
    i_start_of_lane = '0;
    i_resync        = 4'b0100;
    idle_cycles(2);
    random_skews(10);
    run_until(1'b0);
    repeat (2 * MARKER_PERIOD) drive_beat();

    // Lane 1 repeats one byte, so its markers come a beat late
    test_name    = "marker_shift";
    check_stream = 1'b0;
    skew[1]      = skew[1] + 1;
    update_reference();
    run_until(1'b0);
    run_until(1'b1);
    check_stream = 1'b1;
    repeat (2 * MARKER_PERIOD) drive_beat();

    test_name = "skew_overflow";
    @(posedge i_clock);
    #1;
    i_enable = 1'b0;
    idle_cycles(2);
    i_enable = 1'b1;
    skew[0]  = 0;
    skew[1]  = 0;
    skew[2]  = 0;
    skew[3]  = 15;
    beat     = 0;
    update_reference();
    in_skew_test  = 1'b1;
    errors_before = skew_errors;
    repeat (4 * MARKER_PERIOD) drive_beat();
    in_skew_test = 1'b0;
    if (skew_errors == errors_before)
    begin
      event_failure("no skew error pulse for a 15 beat skew");
    end

    idle_cycles(2);
    $display("Checks done, error count %0d", errors);
    if (errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/deskew_pkg.sv
logic/deskew_ctrl_if.sv
logic/deskew_fsm.sv
logic/skew_counter.sv
logic/lane_delay_line.sv
logic/deskew_top.sv
verification/deskew_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module deskew_tb -f sim.f

output=$(./obj_dir/Vdeskew_tb)
echo "$output"

if echo "$output" | grep -qx "All tests passed"
then
  exit 0
fi
exit 1
